// File: mbox_config.svh
// mailbox build configuration
`ifndef MBOX_CONFIG_SVH
`define MBOX_CONFIG_SVH

// width of a data word and of every register in the mailbox
`define MBOX_DATA_W 32

// number of words the internal buffer can hold
// the write pointer saturates when it reaches this count
`define MBOX_DEPTH 64

// width of the user id carried with each request
// a soc owner is matched against this id on every access
`define MBOX_USER_W 8

// width of the register word offset on the request port
// nine registers are decoded out of this field
`define MBOX_ADDR_W 4

`endif

// File: mbox_pkg.sv
// mailbox shared types
`include "mbox_config.svh"

package mbox_pkg;

    // lock and protocol states, error is left only by a forced unlock
    typedef enum logic [2:0] {
        fsm_idle     = 3'd0,
        fsm_rdy_cmd  = 3'd1,
        fsm_rdy_dlen = 3'd2,
        fsm_rdy_data = 3'd3,
        fsm_exec_uc  = 3'd4,
        fsm_exec_soc = 3'd5,
        fsm_error    = 3'd6
    } mbox_fsm_e;

    // register word offsets seen on the request port
    typedef enum logic [`MBOX_ADDR_W-1:0] {
        reg_lock    = 4'd0,
        reg_user    = 4'd1,
        reg_cmd     = 4'd2,
        reg_dlen    = 4'd3,
        reg_datain  = 4'd4,
        reg_dataout = 4'd5,
        reg_execute = 4'd6,
        reg_status  = 4'd7,
        reg_unlock  = 4'd8
    } mbox_reg_e;

    // one request from either agent, soc is set for the external side
    typedef struct packed {
        mbox_reg_e               addr;
        logic                    write;
        logic                    soc;
        logic [`MBOX_USER_W-1:0] user;
        logic [`MBOX_DATA_W-1:0] wdata;
    } mbox_req_t;

    // request held for the single cycle in which it is judged
    typedef struct packed {
        logic      active;
        mbox_req_t req;
    } mbox_access_t;

    typedef struct packed {
        logic axs_without_lock;
        logic axs_incorrect_order;
    } mbox_prot_err_t;

    typedef struct packed {
        logic push;
        logic pop;
        logic restart;
        logic latch_len;
    } mbox_buf_cmd_t;

endpackage

// File: mbox_host_if.sv
// mailbox register front end
`timescale 1ns/1ps
`include "mbox_config.svh"

module mbox_host_if
    import mbox_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_b,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  mbox_req_t               req,
    output logic                    rsp_valid,
    output logic [`MBOX_DATA_W-1:0] rsp_rdata,
    output logic                    rsp_err,
    output mbox_access_t            acc,
    input  logic                    grant,
    input  logic                    drop,
    input  logic                    lock,
    input  mbox_fsm_e               fsm,
    input  logic [`MBOX_USER_W-1:0] owner_user,
    input  logic                    status_clr,
    input  logic [`MBOX_DATA_W-1:0] dataout,
    output logic                    execute,
    output logic [`MBOX_DATA_W-1:0] dlen
);

    logic                    accept;
    logic                    acc_active;
    mbox_req_t               acc_req;
    logic                    wr_ok;
    logic [`MBOX_DATA_W-1:0] cmd_q;
    logic [3:0]              status_q;
    logic [`MBOX_DATA_W-1:0] rdata;

    // one request in flight, so ready drops while it is judged and answered
    assign req_ready = ~(acc_active | rsp_valid);
    assign accept    = req_valid & req_ready;
    assign acc       = '{active: acc_active, req: acc_req};

    // register writes land only when the controller grants them
    assign wr_ok = acc_active & acc_req.write & grant;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            acc_active <= 1'b0;
            rsp_valid  <= 1'b0;
            rsp_err    <= 1'b0;
        end else begin
            acc_active <= accept;
            rsp_valid  <= acc_active;
            // drop is already qualified by an active access
            rsp_err    <= drop;
        end
    end

    // the response carries register values from before this access takes effect
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_req <= req;
        end
        if (acc_active) begin
            rsp_rdata <= drop ? '0 : rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            cmd_q    <= '0;
            dlen     <= '0;
            execute  <= 1'b0;
            status_q <= '0;
        end else begin
            if (wr_ok && acc_req.addr == reg_cmd) begin
                cmd_q <= acc_req.wdata;
            end
            if (wr_ok && acc_req.addr == reg_dlen) begin
                dlen <= acc_req.wdata;
            end
            // returning to idle wipes the handshake registers
            if (status_clr) begin
                execute  <= 1'b0;
                status_q <= '0;
            end else begin
                if (wr_ok && acc_req.addr == reg_execute) begin
                    execute <= acc_req.wdata[0];
                end
                if (wr_ok && acc_req.addr == reg_status) begin
                    status_q <= acc_req.wdata[3:0];
                end
            end
        end
    end

    // read data by offset, write only registers read back as zero
    always_comb begin
        rdata = '0;
        case (acc_req.addr)
            reg_lock:    rdata[0] = lock;
            reg_user:    rdata[`MBOX_USER_W-1:0] = owner_user;
            reg_cmd:     rdata = cmd_q;
            reg_dlen:    rdata = dlen;
            reg_dataout: rdata = dataout;
            reg_execute: rdata[0] = execute;
            reg_status: begin
                rdata[3:0] = status_q;
                rdata[6:4] = fsm;
            end
            default:     rdata = '0;
        endcase
    end

endmodule

// File: mbox_ctrl.sv
// mailbox lock and protocol controller
`timescale 1ns/1ps
`include "mbox_config.svh"

module mbox_ctrl
    import mbox_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_b,
    input  mbox_access_t                        acc,
    input  logic                                execute,
    input  logic [$clog2(`MBOX_DEPTH):0]        buf_wr_count,
    output logic                                grant,
    output logic                                drop,
    output logic                                lock,
    output mbox_fsm_e                           fsm,
    output logic [`MBOX_USER_W-1:0]             owner_user,
    output logic                                status_clr,
    output mbox_buf_cmd_t                       buf_cmd,
    output logic                                uc_data_avail,
    output logic                                soc_data_avail,
    output mbox_prot_err_t                      prot_err
);

    localparam int CNT_W = $clog2(`MBOX_DEPTH) + 1;
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`MBOX_DEPTH);

    mbox_fsm_e      fsm_nxt;
    mbox_prot_err_t prot_err_nxt;
    logic           soc_owner;
    logic           wr_acc;
    logic           rd_acc;
    logic           valid_requester;
    logic           valid_receiver;
    logic           free_axs;
    logic           rdy_state;
    logic           exec_state;
    logic           right_reg;
    logic           acquire;
    logic           exec_set;
    logic           exec_clr;
    logic           force_unlock;

    assign wr_acc = acc.active & acc.req.write;
    assign rd_acc = acc.active & ~acc.req.write;

    assign rdy_state  = (fsm == fsm_rdy_cmd) | (fsm == fsm_rdy_dlen) | (fsm == fsm_rdy_data);
    assign exec_state = (fsm == fsm_exec_uc) | (fsm == fsm_exec_soc);

    // the owner is the requester, a soc owner must also present its own user id
    assign valid_requester = lock & (acc.req.soc ? (soc_owner & (acc.req.user == owner_user))
                                                 : ~soc_owner);
    // the other side may act only once the data is handed over to it
    assign valid_receiver = lock & (acc.req.soc ? (~soc_owner & (fsm == fsm_exec_soc))
                                                : (soc_owner & (fsm == fsm_exec_uc)));

    // lock, user and status reads are open to anyone, and so is a uc unlock
    assign free_axs = (~acc.req.write & (acc.req.addr inside {reg_lock, reg_user, reg_status}))
                    | (acc.req.write & ~acc.req.soc & (acc.req.addr == reg_unlock));
    assign drop = acc.active & ~(valid_requester | valid_receiver | free_axs);

    // which write a valid requester is allowed to make in each filling state
    always_comb begin
        case (fsm)
            fsm_rdy_cmd:  right_reg = acc.req.addr == reg_cmd;
            fsm_rdy_dlen: right_reg = acc.req.addr == reg_dlen;
            fsm_rdy_data: right_reg = acc.req.addr inside {reg_datain, reg_execute};
            default:      right_reg = 1'b0;
        endcase
    end

    always_comb begin
        grant = 1'b0;
        if (wr_acc) begin
            case (acc.req.addr)
                reg_cmd:     grant = valid_requester & (fsm == fsm_rdy_cmd);
                reg_dlen:    grant = valid_requester & (fsm == fsm_rdy_dlen);
                // pushes stop once the buffer is full
                reg_datain:  grant = valid_requester & (fsm == fsm_rdy_data)
                                   & (buf_wr_count < FULL_CNT);
                reg_execute: grant = valid_requester & (acc.req.wdata[0] ? (fsm == fsm_rdy_data)
                                                                         : exec_state);
                reg_status:  grant = valid_receiver;
                reg_unlock:  grant = ~acc.req.soc & acc.req.wdata[0];
                default:     grant = 1'b0;
            endcase
        end
    end

    assign acquire      = rd_acc & (acc.req.addr == reg_lock) & ~lock & (fsm == fsm_idle);
    assign exec_set     = grant & (acc.req.addr == reg_execute) & acc.req.wdata[0];
    assign exec_clr     = grant & (acc.req.addr == reg_execute) & ~acc.req.wdata[0] & execute;
    assign force_unlock = grant & (acc.req.addr == reg_unlock);
    assign status_clr   = exec_clr | force_unlock;

    // only soc accesses are policed, the uc is trusted to follow the sequence
    assign prot_err_nxt.axs_without_lock    = wr_acc & acc.req.soc & (fsm == fsm_idle);
    assign prot_err_nxt.axs_incorrect_order = wr_acc & acc.req.soc & valid_requester
                                            & rdy_state & ~right_reg;

    always_comb begin
        fsm_nxt = fsm;
        case (fsm)
            fsm_idle:     if (acquire) fsm_nxt = fsm_rdy_cmd;
            fsm_rdy_cmd:  if (grant && acc.req.addr == reg_cmd) fsm_nxt = fsm_rdy_dlen;
            fsm_rdy_dlen: if (grant && acc.req.addr == reg_dlen) fsm_nxt = fsm_rdy_data;
            // data goes to the side that did not set execute
            fsm_rdy_data: if (exec_set) fsm_nxt = soc_owner ? fsm_exec_uc : fsm_exec_soc;
            fsm_exec_uc,
            fsm_exec_soc: if (exec_clr) fsm_nxt = fsm_idle;
            default:      fsm_nxt = fsm;
        endcase
        if (prot_err_nxt.axs_incorrect_order) begin
            fsm_nxt = fsm_error;
        end
        // forced unlock wins from any state, the error state included
        if (force_unlock) begin
            fsm_nxt = fsm_idle;
        end
    end

    // pointers restart on the hand-over and whenever the mailbox goes back to idle
    assign buf_cmd.push      = grant & (acc.req.addr == reg_datain);
    assign buf_cmd.pop       = rd_acc & (acc.req.addr == reg_dataout) & valid_receiver;
    assign buf_cmd.restart   = exec_set | status_clr;
    assign buf_cmd.latch_len = exec_set;

    assign uc_data_avail  = fsm == fsm_exec_uc;
    assign soc_data_avail = fsm == fsm_exec_soc;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            fsm        <= fsm_idle;
            lock       <= 1'b0;
            soc_owner  <= 1'b0;
            owner_user <= '0;
            prot_err   <= '0;
        end else begin
            fsm      <= fsm_nxt;
            prot_err <= prot_err_nxt;
            if (acquire) begin
                lock       <= 1'b1;
                soc_owner  <= acc.req.soc;
                owner_user <= acc.req.user;
            end else if (status_clr) begin
                lock <= 1'b0;
            end
        end
    end

endmodule

// File: mbox_buffer.sv
// mailbox word buffer
`timescale 1ns/1ps
`include "mbox_config.svh"

module mbox_buffer
    import mbox_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_b,
    input  mbox_access_t                  acc,
    input  mbox_buf_cmd_t                 buf_cmd,
    input  logic [`MBOX_DATA_W-1:0]       dlen,
    output logic [$clog2(`MBOX_DEPTH):0]  buf_wr_count,
    output logic [`MBOX_DATA_W-1:0]       dataout
);

    localparam int IDX_W = $clog2(`MBOX_DEPTH);
    localparam int CNT_W = IDX_W + 1;
    localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(`MBOX_DEPTH);

    logic [`MBOX_DATA_W-1:0] mem [`MBOX_DEPTH];
    logic [CNT_W-1:0]        wr_ptr;
    logic [CNT_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        len_q;
    logic [CNT_W-1:0]        len_nxt;
    logic [CNT_W-1:0]        dlen_cap;
    logic [`MBOX_DATA_W-1:0] dlen_words;
    logic                    wr_en;
    logic                    rd_ok;

    // a byte count rounds up to whole words
    assign dlen_words = {2'b00, dlen[`MBOX_DATA_W-1:2]} + `MBOX_DATA_W'(|dlen[1:0]);
    assign dlen_cap   = (dlen_words > `MBOX_DATA_W'(`MBOX_DEPTH)) ? DEPTH_C
                                                                  : dlen_words[CNT_W-1:0];
    // the receiver never reads past what the sender actually wrote
    assign len_nxt = (dlen_cap < wr_ptr) ? dlen_cap : wr_ptr;

    assign wr_en = buf_cmd.push & (wr_ptr < DEPTH_C);
    assign rd_ok = rd_ptr < len_q;

    assign buf_wr_count = wr_ptr;
    assign dataout      = rd_ok ? mem[rd_ptr[IDX_W-1:0]] : '0;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[IDX_W-1:0]] <= acc.req.wdata;
        end
    end

    // the length is sampled from the write pointer before the restart clears it
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            len_q  <= '0;
        end else begin
            if (buf_cmd.latch_len) begin
                len_q <= len_nxt;
            end
            if (buf_cmd.restart) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (wr_en) wr_ptr <= wr_ptr + 1'b1;
                if (buf_cmd.pop && rd_ok) rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: mbox_top.sv
// mailbox top level
`timescale 1ns/1ps
`include "mbox_config.svh"

module mbox_top
    import mbox_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_b,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  mbox_req_t               req,
    output logic                    rsp_valid,
    output logic [`MBOX_DATA_W-1:0] rsp_rdata,
    output logic                    rsp_err,
    output logic                    uc_data_avail,
    output logic                    soc_data_avail,
    output mbox_prot_err_t          prot_err
);

    mbox_access_t                 acc;
    mbox_buf_cmd_t                buf_cmd;
    mbox_fsm_e                    fsm;
    logic                         grant;
    logic                         drop;
    logic                         lock;
    logic                         status_clr;
    logic                         execute;
    logic [`MBOX_USER_W-1:0]      owner_user;
    logic [`MBOX_DATA_W-1:0]      dlen;
    logic [`MBOX_DATA_W-1:0]      dataout;
    logic [$clog2(`MBOX_DEPTH):0] buf_wr_count;

    // register port, holds the access and answers it a cycle later
    mbox_host_if u_host_if (
        .clk, .rst_b, .req_valid, .req_ready, .req, .rsp_valid, .rsp_rdata, .rsp_err,
        .acc, .grant, .drop, .lock, .fsm, .owner_user, .status_clr, .dataout,
        .execute, .dlen
    );

    // judges every access and steers the buffer
    mbox_ctrl u_ctrl (
        .clk, .rst_b, .acc, .execute, .buf_wr_count, .grant, .drop, .lock, .fsm,
        .owner_user, .status_clr, .buf_cmd, .uc_data_avail, .soc_data_avail, .prot_err
    );

    mbox_buffer u_buffer (
        .clk, .rst_b, .acc, .buf_cmd, .dlen, .buf_wr_count, .dataout
    );

endmodule

// File: mbox_chk.sv
// mailbox interface assertions
`timescale 1ns/1ps

module mbox_chk
    import mbox_pkg::*;
(
    input logic           clk,
    input logic           rst_b,
    input logic           req_valid,
    input logic           req_ready,
    input logic           rsp_valid,
    input logic           uc_data_avail,
    input logic           soc_data_avail,
    input mbox_prot_err_t prot_err
);

    // a response is seen exactly two edges after its request was accepted, and never otherwise
    rsp_timing_a: assert property (@(posedge clk) disable iff (!rst_b)
        rsp_valid == $past(req_valid && req_ready, 2))
        else $error("rsp_valid does not follow an accepted request by one cycle");

    // only one request may be in flight
    ready_low_a: assert property (@(posedge clk) disable iff (!rst_b)
        rsp_valid |-> !req_ready)
        else $error("req_ready is high during a response");

    avail_onehot_a: assert property (@(posedge clk) disable iff (!rst_b)
        !(uc_data_avail && soc_data_avail))
        else $error("both data_avail flags are high");

    // a single access can break only one protocol rule
    prot_err_onehot_a: assert property (@(posedge clk) disable iff (!rst_b)
        !(prot_err.axs_without_lock && prot_err.axs_incorrect_order))
        else $error("both prot_err bits are high");

endmodule

bind mbox_top mbox_chk chk0 (
    .clk            (clk),
    .rst_b          (rst_b),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .rsp_valid      (rsp_valid),
    .uc_data_avail  (uc_data_avail),
    .soc_data_avail (soc_data_avail),
    .prot_err       (prot_err)
);

// File: tb_mbox.sv
// mailbox testbench
`timescale 1ns/1ps
`include "mbox_config.svh"

module tb_mbox
    import mbox_pkg::*;
();

    // six transfers and a few single steps come to under 200 accesses of 3 cycles each
    // so about 600 cycles are needed, and the limit leaves wide margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int DEPTH = `MBOX_DEPTH;

    // one predicted response, with the side flags seen after the access lands
    typedef struct packed {
        logic [`MBOX_DATA_W-1:0] rdata;
        logic                    err;
        mbox_prot_err_t          perr;
        logic                    uc_av;
        logic                    soc_av;
    } exp_t;

    logic                    clk;
    logic                    rst_b;
    logic                    req_valid;
    logic                    req_ready;
    mbox_req_t               req;
    logic                    rsp_valid;
    logic [`MBOX_DATA_W-1:0] rsp_rdata;
    logic                    rsp_err;
    logic                    uc_data_avail;
    logic                    soc_data_avail;
    mbox_prot_err_t          prot_err;

    exp_t                    exp_q[$];
    exp_t                    mon_exp;
    int                      cycles = 0;
    int                      n;
    logic                    pass_shown = 1'b0;
    logic                    fail_shown = 1'b0;

    // model of the mailbox as the requesters see it
    mbox_fsm_e               m_state;
    logic                    m_lock;
    logic                    m_soc_owner;
    logic [`MBOX_USER_W-1:0] m_user;
    logic [`MBOX_DATA_W-1:0] m_cmd;
    logic [`MBOX_DATA_W-1:0] m_dlen;
    logic                    m_execute;
    logic [3:0]              m_status;
    logic [`MBOX_DATA_W-1:0] m_mem [DEPTH];
    int                      m_wr;
    int                      m_rd;
    int                      m_len;

    mbox_top dut0 (
        .clk, .rst_b, .req_valid, .req_ready, .req, .rsp_valid, .rsp_rdata, .rsp_err,
        .uc_data_avail, .soc_data_avail, .prot_err
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string why);
        fail_shown = 1'b1;
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: time %0t ns, %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // the end of a transfer frees the lock but keeps the old owner id readable
    function automatic void model_release();
        m_state   = fsm_idle;
        m_lock    = 1'b0;
        m_execute = 1'b0;
        m_status  = 4'd0;
        m_wr      = 0;
        m_rd      = 0;
    endfunction

    function automatic void model_reset();
        model_release();
        m_soc_owner = 1'b0;
        m_user      = '0;
        m_cmd       = '0;
        m_dlen      = '0;
        m_len       = 0;
    endfunction

    // predicts one response and applies the access to the model state
    function automatic exp_t ref_model(input mbox_req_t r);
        exp_t        e;
        logic        vreq;
        logic        vrec;
        logic        free_axs;
        logic        drop;
        logic        grant;
        logic        in_rdy;
        logic        right_reg;
        logic [31:0] rd;
        int          words;
        e = '0;
        grant = 1'b0;
        vreq = m_lock && (r.soc ? (m_soc_owner && r.user == m_user) : !m_soc_owner);
        vrec = m_lock && (r.soc ? (!m_soc_owner && m_state == fsm_exec_soc)
                                : (m_soc_owner && m_state == fsm_exec_uc));
        free_axs = r.write ? (!r.soc && r.addr == reg_unlock)
                           : (r.addr inside {reg_lock, reg_user, reg_status});
        drop = !(vreq || vrec || free_axs);
        case (r.addr)
            reg_lock:    rd = {31'd0, m_lock};
            reg_user:    rd = {24'd0, m_user};
            reg_cmd:     rd = m_cmd;
            reg_dlen:    rd = m_dlen;
            reg_dataout: rd = (m_rd < m_len) ? m_mem[m_rd] : 32'd0;
            reg_execute: rd = {31'd0, m_execute};
            reg_status:  rd = {25'd0, m_state, m_status};
            default:     rd = 32'd0;
        endcase
        e.rdata = drop ? 32'd0 : rd;
        e.err   = drop;
        // the soc side is checked against the fill order, the uc is not
        in_rdy = m_state inside {fsm_rdy_cmd, fsm_rdy_dlen, fsm_rdy_data};
        right_reg = (m_state == fsm_rdy_cmd && r.addr == reg_cmd)
                 || (m_state == fsm_rdy_dlen && r.addr == reg_dlen)
                 || (m_state == fsm_rdy_data && r.addr inside {reg_datain, reg_execute});
        e.perr.axs_without_lock    = r.write && r.soc && m_state == fsm_idle;
        e.perr.axs_incorrect_order = r.write && r.soc && vreq && in_rdy && !right_reg;
        if (r.write) begin
            case (r.addr)
                reg_cmd:     grant = vreq && m_state == fsm_rdy_cmd;
                reg_dlen:    grant = vreq && m_state == fsm_rdy_dlen;
                reg_datain:  grant = vreq && m_state == fsm_rdy_data && m_wr < DEPTH;
                reg_execute: grant = vreq && (r.wdata[0] ? m_state == fsm_rdy_data
                                   : m_state inside {fsm_exec_uc, fsm_exec_soc});
                reg_status:  grant = vrec;
                reg_unlock:  grant = !r.soc && r.wdata[0];
                default:     grant = 1'b0;
            endcase
            if (grant && r.addr == reg_cmd) begin
                m_cmd   = r.wdata;
                m_state = fsm_rdy_dlen;
            end
            if (grant && r.addr == reg_dlen) begin
                m_dlen  = r.wdata;
                m_state = fsm_rdy_data;
            end
            if (grant && r.addr == reg_datain) begin
                m_mem[m_wr] = r.wdata;
                m_wr = m_wr + 1;
            end
            // the readable count is the byte length in whole words, clipped by what was written
            if (grant && r.addr == reg_execute && r.wdata[0]) begin
                words = int'((64'(m_dlen) + 64'd3) / 64'd4);
                m_len = (words < m_wr) ? words : m_wr;
                m_len = (m_len < DEPTH) ? m_len : DEPTH;
                m_wr = 0;
                m_rd = 0;
                m_execute = 1'b1;
                m_state = m_soc_owner ? fsm_exec_uc : fsm_exec_soc;
            end
            if (grant && r.addr == reg_execute && !r.wdata[0]) model_release();
            if (grant && r.addr == reg_status) m_status = r.wdata[3:0];
            if (grant && r.addr == reg_unlock) model_release();
            if (e.perr.axs_incorrect_order) m_state = fsm_error;
        end else begin
            if (r.addr == reg_lock && !m_lock && m_state == fsm_idle) begin
                m_lock      = 1'b1;
                m_soc_owner = r.soc;
                m_user      = r.user;
                m_state     = fsm_rdy_cmd;
            end
            if (r.addr == reg_dataout && vrec && m_rd < m_len) m_rd = m_rd + 1;
        end
        e.uc_av  = m_state == fsm_exec_uc;
        e.soc_av = m_state == fsm_exec_soc;
        return e;
    endfunction

    // holds the request until ready, then waits out its response
    task automatic issue_request(input logic wr, input logic soc, input logic [7:0] user,
                                 input mbox_reg_e addr, input logic [31:0] wdata);
        mbox_req_t r;
        r.addr  = addr;
        r.write = wr;
        r.soc   = soc;
        r.user  = user;
        r.wdata = wdata;
        req       = r;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        exp_q.push_back(ref_model(r));
        #1;
        req_valid = 1'b0;
        do begin
            @(negedge clk);
        end while (!rsp_valid);
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic soc, input logic [7:0] user, input mbox_reg_e addr,
                             input logic [31:0] wdata);
        issue_request(1'b1, soc, user, addr, wdata);
    endtask

    task automatic read_reg(input logic soc, input logic [7:0] user, input mbox_reg_e addr);
        issue_request(1'b0, soc, user, addr, 32'd0);
    endtask

    // full lock, fill, hand-over, drain and release, with an optional wrong-user soc
    task automatic run_transfer(input logic soc_snd, input logic [7:0] user, input int nw,
                                input int dlen_b, input logic intrude);
        int i;
        read_reg(soc_snd, user, reg_lock);
        write_reg(soc_snd, user, reg_cmd, $urandom);
        write_reg(soc_snd, user, reg_dlen, 32'(dlen_b));
        for (i = 0; i < nw; i++) begin
            write_reg(soc_snd, user, reg_datain, $urandom);
            if (intrude && i == 0) begin
                write_reg(1'b1, user ^ 8'hff, reg_datain, $urandom);
                read_reg(1'b1, user ^ 8'hff, reg_cmd);
            end
        end
        write_reg(soc_snd, user, reg_execute, 32'd1);
        read_reg(~soc_snd, 8'h77, reg_cmd);
        read_reg(~soc_snd, 8'h77, reg_dlen);
        for (i = 0; i < nw + 2; i++) begin
            read_reg(~soc_snd, 8'h77, reg_dataout);
        end
        write_reg(~soc_snd, 8'h77, reg_status, $urandom % 16);
        read_reg(~soc_snd, 8'h77, reg_status);
        write_reg(soc_snd, user, reg_execute, 32'd0);
    endtask

    always @(negedge clk) begin
        if (rst_b && rsp_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("a response arrived with no request outstanding");
            end else begin
                mon_exp = exp_q.pop_front();
                check_val("rsp_rdata", rsp_rdata, mon_exp.rdata);
                check_val("rsp_err", 32'(rsp_err), 32'(mon_exp.err));
                check_val("prot_err", {30'd0, prot_err}, {30'd0, mon_exp.perr});
                check_val("uc_data_avail", 32'(uc_data_avail), 32'(mon_exp.uc_av));
                check_val("soc_data_avail", 32'(soc_data_avail), 32'(mon_exp.soc_av));
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run("the run did not finish within the cycle limit");
        end
    end

    initial begin
        void'($urandom(32'h54db));
        rst_b     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        model_reset();
        repeat (5) @(posedge clk);
        #1;
        rst_b = 1'b1;
        check_val("req_ready", 32'(req_ready), 32'd1);
        check_val("rsp_valid", 32'(rsp_valid), 32'd0);
        check_val("uc_data_avail", 32'(uc_data_avail), 32'd0);
        check_val("soc_data_avail", 32'(soc_data_avail), 32'd0);
        check_val("prot_err", {30'd0, prot_err}, 32'd0);

        // lock taken by the soc, seen as held by a second read and by the uc
        read_reg(1'b1, 8'h5a, reg_lock);
        read_reg(1'b1, 8'h5a, reg_lock);
        read_reg(1'b1, 8'h5a, reg_user);
        read_reg(1'b0, 8'h00, reg_lock);
        write_reg(1'b0, 8'h00, reg_unlock, 32'd1);

        n = 1 + int'($urandom % 16);
        run_transfer(1'b1, 8'h5a, n, n * 4, 1'b0);

        // length longer than the data, not word aligned, and shorter than the data
        n = 1 + int'($urandom % 8);
        run_transfer(1'b1, 8'h5a, n, (n + 3) * 4, 1'b0);
        run_transfer(1'b1, 8'h5a, 5, 18, 1'b0);
        run_transfer(1'b1, 8'h5a, 6, 8, 1'b0);

        run_transfer(1'b1, 8'h5a, 3, 12, 1'b1);

        // soc write with no lock, then a datain write before the cmd
        write_reg(1'b1, 8'h5a, reg_cmd, $urandom);
        read_reg(1'b1, 8'h5a, reg_lock);
        write_reg(1'b1, 8'h5a, reg_datain, $urandom);
        read_reg(1'b1, 8'h5a, reg_status);
        write_reg(1'b0, 8'h00, reg_unlock, 32'd1);
        read_reg(1'b0, 8'h00, reg_status);

        // uc sends to the soc, then status is clear and the lock is free again
        n = 1 + int'($urandom % 16);
        run_transfer(1'b0, 8'h00, n, n * 4, 1'b0);
        read_reg(1'b0, 8'h00, reg_status);
        read_reg(1'b0, 8'h00, reg_lock);
        write_reg(1'b0, 8'h00, reg_unlock, 32'd1);

        if (exp_q.size() != 0) begin
            fail_run("some requests never received a response");
        end else begin
            pass_shown = 1'b1;
            $display("Done: no errors");
            $finish;
        end
    end

    final begin
        if (!pass_shown && !fail_shown) begin
            $display("Done: errors found");
        end
    end

endmodule

// File: vlog.f
+incdir+.
mbox_pkg.sv
mbox_host_if.sv
mbox_ctrl.sv
mbox_buffer.sv
mbox_top.sv
mbox_chk.sv
tb_mbox.sv

// File: Makefile
# Verilator build and run for the mailbox testbench

VERILATOR ?= verilator
TOP       ?= tb_mbox
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
